// ==== files.f ====
common/drive_cfg_pkg.sv
common/drive_types_pkg.sv
src/sync_ram.sv
decode/inst_decoder.sv
envelope/envelope_reader.sv
nco/nco_bank.sv
modulation/polar_modulator.sv
src/drive_signal_gen.sv
testbench/tb_drive_signal_gen.sv

// ==== Bender.yml ====
package:
  name: drive_signal_gen

sources:
  - common/drive_cfg_pkg.sv
  - common/drive_types_pkg.sv
  - src/sync_ram.sv
  - decode/inst_decoder.sv
  - envelope/envelope_reader.sv
  - nco/nco_bank.sv
  - modulation/polar_modulator.sv
  - src/drive_signal_gen.sv
  - target: test
    files:
      - testbench/tb_drive_signal_gen.sv

// ==== testbench/tb_drive_signal_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_drive_signal_gen
    import drive_cfg_pkg::*;
    import drive_types_pkg::*;
();

    localparam int DRIVE_DLY = 2;
    localparam int NUM_STEPS = 12;
    localparam int LOAD_CYCLES = 2**PC_W + NUM_QUBIT * INST_TABLE_DEPTH
                               + 2**ENV_ADDR_W + 2 * 2**PHASE_W;
    localparam int STEP_OVERHEAD = 24;
    localparam int MARGIN = 50;

    // pulse selectors for wait_for_pulse
    localparam int P_INST  = 0;
    localparam int P_ENTRY = 1;
    localparam int P_RZ    = 2;
    localparam int P_DONE  = 3;

    logic                   clk;
    logic                   rst;
    logic                   inst_wr_en_i;
    logic [PC_W-1:0]        inst_wr_addr_i;
    inst_word_t             inst_wr_data_i;
    logic                   table_wr_en_i;
    logic [QUBIT_W-1:0]     table_wr_qubit_i;
    logic [INST_SEL_W-1:0]  table_wr_addr_i;
    table_entry_t           table_wr_data_i;
    logic                   env_wr_en_i;
    logic [ENV_ADDR_W-1:0]  env_wr_addr_i;
    env_word_t              env_wr_data_i;
    logic                   sin_wr_en_i;
    logic                   cos_wr_en_i;
    phase_t                 lut_wr_addr_i;
    logic signed [LUT_W-1:0] lut_wr_data_i;
    logic                   ftw_wr_en_i;
    logic [QUBIT_W-1:0]     ftw_qubit_i;
    logic [FTW_W-1:0]       ftw_data_i;
    logic                   pc_valid_i;
    logic [PC_W-1:0]        pc_i;
    logic                   inst_valid_o;
    logic                   entry_valid_o;
    logic                   rz_done_o;
    logic                   start_read_i;
    logic                   reading_o;
    logic                   read_done_o;
    logic                   valid_o;
    iq_t                    i_o;
    iq_t                    q_o;

    // testbench copies of every memory
    inst_word_t              list_mem [2**PC_W];
    table_entry_t            tbl_mem [NUM_QUBIT][INST_TABLE_DEPTH];
    env_word_t               env_mem [2**ENV_ADDR_W];
    logic signed [LUT_W-1:0] sin_mem [2**PHASE_W];
    logic signed [LUT_W-1:0] cos_mem [2**PHASE_W];

    // nco model
    logic [FTW_W-1:0]       model_ftw [NUM_QUBIT];
    logic [FTW_W-1:0]       model_acc [NUM_QUBIT];
    phase_t                 model_off [NUM_QUBIT];

    // expected samples, due cycle plus i and q
    int                     due_q [$];
    logic [IQ_W-1:0]        exp_i_q [$];
    logic [IQ_W-1:0]        exp_q_q [$];

    logic [31:0]            rng_state = 32'hf5cc;
    int                     cyc = 0;
    int                     cycle_limit = 0;
    int                     sample_count = 0;

    // step table: pc, tuning word of the word's qubit, expected sample count
    int step_pc  [NUM_STEPS] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11};
    int step_ftw [NUM_STEPS] = '{'h0000, 'h0000, 'h0000, 'h0000, 'h0000, 'h0000,
                                 'h0000, 'h0300, 'h0500, 'h0300, 'h0300, 'hff00};
    int step_len [NUM_STEPS] = '{3, 4, 0, 3, 4, 0, 0, 7, 11, 0, 7, 7};

    drive_signal_gen dut0 (.*);

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [IQ_W-1:0] scale_sample(input int amp, input int lut);
        int prod;
        prod = amp * lut;
        return IQ_W'(prod >>> IQ_SHIFT);
    endfunction

    function automatic logic pulse_level(input int sel);
        case (sel)
            P_INST:  return inst_valid_o;
            P_ENTRY: return entry_valid_o;
            P_RZ:    return rz_done_o;
            default: return read_done_o;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("ERROR time=%0t: %s", $time, why);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s: got %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_for_pulse(input int sel, output int at);
        @(negedge clk);
        while (!pulse_level(sel)) begin
            @(negedge clk);
        end
        at = cyc;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // cycle count, watchdog and nco model

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > cycle_limit) begin
            fail_run("run exceeded its cycle limit");
        end
    end

    always @(posedge clk) begin
        for (int q = 0; q < NUM_QUBIT; q++) begin
            if (rst) begin
                model_ftw[q] <= '0;
                model_acc[q] <= '0;
            end else if (ftw_wr_en_i && ftw_qubit_i == QUBIT_W'(q)) begin
                model_ftw[q] <= ftw_data_i;
                model_acc[q] <= '0;
            end else begin
                model_acc[q] <= model_acc[q] + model_ftw[q];
            end
        end
    end

    // output samples checked mid-cycle
    always @(negedge clk) begin
        if (!rst && valid_o) begin
            if (due_q.size() == 0) begin
                fail_run("valid_o pulsed with no sample expected");
            end
            check_value("valid_o cycle", cyc, due_q[0]);
            check_value("i_o", i_o[IQ_W-1:0], exp_i_q[0]);
            check_value("q_o", q_o[IQ_W-1:0], exp_q_q[0]);
            void'(due_q.pop_front());
            void'(exp_i_q.pop_front());
            void'(exp_q_q.pop_front());
            sample_count = sample_count + 1;
        end
        if (due_q.size() != 0 && due_q[0] < cyc) begin
            fail_run("an expected sample never appeared on valid_o");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory contents and loading

    task automatic build_memories();
        for (int a = 0; a < 2**PC_W; a++) begin
            rng_state = xorshift32(rng_state);
            list_mem[a] = rng_state[10:0];
        end
        // program: qubit, rz flag, immediate
        list_mem[0]  = {2'd0, 1'b0, 8'h31};
        list_mem[1]  = {2'd1, 1'b0, 8'h09};
        list_mem[2]  = {2'd0, 1'b1, 8'h40};
        list_mem[3]  = {2'd0, 1'b0, 8'h31};
        list_mem[4]  = {2'd1, 1'b0, 8'h09};
        list_mem[5]  = {2'd2, 1'b0, 8'h05};
        list_mem[6]  = {2'd3, 1'b0, 8'h1e};
        list_mem[7]  = {2'd3, 1'b0, 8'h02};
        list_mem[8]  = {2'd2, 1'b0, 8'h07};
        list_mem[9]  = {2'd3, 1'b1, 8'ha5};
        list_mem[10] = {2'd3, 1'b0, 8'h02};
        list_mem[11] = {2'd1, 1'b0, 8'h0c};
        // entry length differs per qubit for the same index
        for (int q = 0; q < NUM_QUBIT; q++) begin
            for (int s = 0; s < INST_TABLE_DEPTH; s++) begin
                rng_state = xorshift32(rng_state);
                tbl_mem[q][s].start_addr = {1'b0, rng_state[6:0]};
                tbl_mem[q][s].stop_addr = tbl_mem[q][s].start_addr + 8'(2 + q + s);
            end
        end
        // empty and reversed ranges
        tbl_mem[2][5] = {8'h60, 8'h60};
        tbl_mem[3][6] = {8'h50, 8'h4d};
        for (int a = 0; a < 2**ENV_ADDR_W; a++) begin
            rng_state = xorshift32(rng_state);
            env_mem[a] = rng_state[15:0];
            sin_mem[a] = rng_state[23:16];
            cos_mem[a] = rng_state[31:24];
        end
    endtask

    task automatic load_dut();
        inst_wr_en_i = 1'b1;
        for (int a = 0; a < 2**PC_W; a++) begin
            inst_wr_addr_i = PC_W'(a);
            inst_wr_data_i = list_mem[a];
            next_cycle();
        end
        inst_wr_en_i = 1'b0;
        table_wr_en_i = 1'b1;
        for (int q = 0; q < NUM_QUBIT; q++) begin
            for (int s = 0; s < INST_TABLE_DEPTH; s++) begin
                table_wr_qubit_i = QUBIT_W'(q);
                table_wr_addr_i = INST_SEL_W'(s);
                table_wr_data_i = tbl_mem[q][s];
                next_cycle();
            end
        end
        table_wr_en_i = 1'b0;
        env_wr_en_i = 1'b1;
        for (int a = 0; a < 2**ENV_ADDR_W; a++) begin
            env_wr_addr_i = ENV_ADDR_W'(a);
            env_wr_data_i = env_mem[a];
            next_cycle();
        end
        env_wr_en_i = 1'b0;
        // sine then cosine over the shared write port
        for (int t = 0; t < 2; t++) begin
            sin_wr_en_i = (t == 0);
            cos_wr_en_i = (t == 1);
            for (int a = 0; a < 2**PHASE_W; a++) begin
                lut_wr_addr_i = PHASE_W'(a);
                lut_wr_data_i = (t == 0) ? sin_mem[a] : cos_mem[a];
                next_cycle();
            end
        end
        sin_wr_en_i = 1'b0;
        cos_wr_en_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and reference model

    // phase is taken in the cycle the address is issued
    task automatic push_expected(input logic [QUBIT_W-1:0] q,
                                 input logic [ENV_ADDR_W-1:0] addr);
        env_word_t env;
        phase_t    ph;
        env = env_mem[addr];
        ph = model_acc[q][FTW_W-1 -: PHASE_W] + model_off[q] + env.phase;
        due_q.push_back(cyc + 4);
        exp_i_q.push_back(scale_sample(env.amp, cos_mem[ph]));
        exp_q_q.push_back(scale_sample(env.amp, sin_mem[ph]));
    endtask

    task automatic run_step(input int s);
        inst_word_t   word;
        table_entry_t entry;
        int           pc_cyc;
        int           mark_cyc;
        int           at;
        int           start_cyc;
        int           n;
        int           base;
        word = list_mem[step_pc[s]];
        base = sample_count;
        ftw_wr_en_i = 1'b1;
        ftw_qubit_i = word.qubit;
        ftw_data_i = FTW_W'(step_ftw[s]);
        next_cycle();
        ftw_wr_en_i = 1'b0;
        pc_valid_i = 1'b1;
        pc_i = PC_W'(step_pc[s]);
        pc_cyc = cyc;
        next_cycle();
        pc_valid_i = 1'b0;
        wait_for_pulse(P_INST, mark_cyc);
        check_value("inst_valid_o latency", mark_cyc - pc_cyc, 2);
        if (word.rz) begin
            wait_for_pulse(P_RZ, at);
            check_value("rz_done_o latency", at - mark_cyc, 2);
            model_off[word.qubit] = model_off[word.qubit] + word.imm;
            next_cycle();
        end else begin
            wait_for_pulse(P_ENTRY, at);
            check_value("entry_valid_o latency", at - mark_cyc, 2);
            entry = tbl_mem[word.qubit][word.imm[INST_SEL_W-1:0]];
            n = (entry.stop_addr > entry.start_addr) ?
                entry.stop_addr - entry.start_addr : 0;
            next_cycle();
            start_read_i = 1'b1;
            start_cyc = cyc;
            next_cycle();
            start_read_i = 1'b0;
            for (int k = 0; k < n; k++) begin
                check_value("reading_o while issuing", reading_o, 1);
                push_expected(word.qubit, entry.start_addr + ENV_ADDR_W'(k));
                next_cycle();
            end
            wait_for_pulse(P_DONE, at);
            check_value("read_done_o cycle", at, start_cyc + n + 1);
            check_value("reading_o at read_done_o", reading_o, 0);
            while (due_q.size() != 0) begin
                @(negedge clk);
            end
            next_cycle();
        end
        check_value("sample count", sample_count - base, step_len[s]);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inst_wr_en_i = 1'b0;
        inst_wr_addr_i = '0;
        inst_wr_data_i = '0;
        table_wr_en_i = 1'b0;
        table_wr_qubit_i = '0;
        table_wr_addr_i = '0;
        table_wr_data_i = '0;
        env_wr_en_i = 1'b0;
        env_wr_addr_i = '0;
        env_wr_data_i = '0;
        sin_wr_en_i = 1'b0;
        cos_wr_en_i = 1'b0;
        lut_wr_addr_i = '0;
        lut_wr_data_i = '0;
        ftw_wr_en_i = 1'b0;
        ftw_qubit_i = '0;
        ftw_data_i = '0;
        pc_valid_i = 1'b0;
        pc_i = '0;
        start_read_i = 1'b0;
        for (int q = 0; q < NUM_QUBIT; q++) begin
            model_off[q] = '0;
        end
        cycle_limit = LOAD_CYCLES + MARGIN;
        for (int s = 0; s < NUM_STEPS; s++) begin
            cycle_limit = cycle_limit + step_len[s] + STEP_OVERHEAD;
        end
        build_memories();

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(negedge clk);
        check_value("inst_valid_o after reset", inst_valid_o, 0);
        check_value("entry_valid_o after reset", entry_valid_o, 0);
        check_value("rz_done_o after reset", rz_done_o, 0);
        check_value("reading_o after reset", reading_o, 0);
        check_value("read_done_o after reset", read_done_o, 0);
        check_value("valid_o after reset", valid_o, 0);

        next_cycle();
        load_dut();
        for (int s = 0; s < NUM_STEPS; s++) begin
            run_step(s);
        end

        // no stray samples after the last step
        repeat (8) @(negedge clk);
        if (due_q.size() != 0) begin
            fail_run("samples still pending at the end of the run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src/drive_signal_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module drive_signal_gen
    import drive_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    // memory and nco configuration
    input  wire                         inst_wr_en_i,
    input  wire [PC_W-1:0]              inst_wr_addr_i,
    input  wire inst_word_t             inst_wr_data_i,
    input  wire                         table_wr_en_i,
    input  wire [QUBIT_W-1:0]           table_wr_qubit_i,
    input  wire [INST_SEL_W-1:0]        table_wr_addr_i,
    input  wire table_entry_t           table_wr_data_i,
    input  wire                         env_wr_en_i,
    input  wire [ENV_ADDR_W-1:0]        env_wr_addr_i,
    input  wire env_word_t              env_wr_data_i,
    input  wire                         sin_wr_en_i,
    input  wire                         cos_wr_en_i,
    input  wire phase_t                 lut_wr_addr_i,
    input  wire signed [LUT_W-1:0]      lut_wr_data_i,
    input  wire                         ftw_wr_en_i,
    input  wire [QUBIT_W-1:0]           ftw_qubit_i,
    input  wire [FTW_W-1:0]             ftw_data_i,
    // sequencing
    input  wire                         pc_valid_i,
    input  wire [PC_W-1:0]              pc_i,
    output logic                        inst_valid_o,
    output logic                        entry_valid_o,
    output logic                        rz_done_o,
    input  wire                         start_read_i,
    output logic                        reading_o,
    output logic                        read_done_o,
    // samples
    output logic                        valid_o,
    output iq_t                         i_o,
    output iq_t                         q_o
);

    logic [QUBIT_W-1:0]     qubit_sel;
    logic                   rz_strobe;
    phase_t                 phase_imm;
    logic [ENV_ADDR_W-1:0]  start_addr;
    logic [ENV_ADDR_W-1:0]  stop_addr;
    logic                   env_valid;
    env_word_t              env_word;
    phase_t                 nco_phase;

    ////////////////////////////////////////////////////////////////////////////
    // decode

    inst_decoder u_decoder (
        .clk              (clk),
        .rst              (rst),
        .inst_wr_en_i     (inst_wr_en_i),
        .inst_wr_addr_i   (inst_wr_addr_i),
        .inst_wr_data_i   (inst_wr_data_i),
        .table_wr_en_i    (table_wr_en_i),
        .table_wr_qubit_i (table_wr_qubit_i),
        .table_wr_addr_i  (table_wr_addr_i),
        .table_wr_data_i  (table_wr_data_i),
        .pc_valid_i       (pc_valid_i),
        .pc_i             (pc_i),
        .inst_valid_o     (inst_valid_o),
        .qubit_sel_o      (qubit_sel),
        .rz_strobe_o      (rz_strobe),
        .phase_imm_o      (phase_imm),
        .entry_valid_o    (entry_valid_o),
        .start_addr_o     (start_addr),
        .stop_addr_o      (stop_addr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // envelope and phase

    envelope_reader u_env_reader (
        .clk           (clk),
        .rst           (rst),
        .env_wr_en_i   (env_wr_en_i),
        .env_wr_addr_i (env_wr_addr_i),
        .env_wr_data_i (env_wr_data_i),
        .start_i       (start_read_i),
        .start_addr_i  (start_addr),
        .stop_addr_i   (stop_addr),
        .reading_o     (reading_o),
        .read_done_o   (read_done_o),
        .env_valid_o   (env_valid),
        .env_o         (env_word)
    );

    nco_bank u_nco_bank (
        .clk         (clk),
        .rst         (rst),
        .ftw_wr_en_i (ftw_wr_en_i),
        .ftw_qubit_i (ftw_qubit_i),
        .ftw_data_i  (ftw_data_i),
        .rz_strobe_i (rz_strobe),
        .phase_imm_i (phase_imm),
        .qubit_sel_i (qubit_sel),
        .rz_done_o   (rz_done_o),
        .nco_phase_o (nco_phase)
    );

    ////////////////////////////////////////////////////////////////////////////
    // iq output

    polar_modulator u_polar_mod (
        .clk           (clk),
        .rst           (rst),
        .sin_wr_en_i   (sin_wr_en_i),
        .cos_wr_en_i   (cos_wr_en_i),
        .lut_wr_addr_i (lut_wr_addr_i),
        .lut_wr_data_i (lut_wr_data_i),
        .valid_i       (env_valid),
        .nco_phase_i   (nco_phase),
        .env_i         (env_word),
        .valid_o       (valid_o),
        .i_o           (i_o),
        .q_o           (q_o)
    );

endmodule

`default_nettype wire

// ==== modulation/polar_modulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module polar_modulator
    import drive_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         sin_wr_en_i,
    input  wire                         cos_wr_en_i,
    input  wire phase_t                 lut_wr_addr_i,
    input  wire signed [LUT_W-1:0]      lut_wr_data_i,
    input  wire                         valid_i,
    input  wire phase_t                 nco_phase_i,
    input  wire env_word_t              env_i,
    output logic                        valid_o,
    output iq_t                         i_o,
    output iq_t                         q_o
);

    phase_t                         lut_addr;
    logic signed [LUT_W-1:0]        sin_data;
    logic signed [LUT_W-1:0]        cos_data;
    logic [AMP_W-1:0]               amp_q;
    logic signed [AMP_W+LUT_W:0]    i_prod_q;
    logic signed [AMP_W+LUT_W:0]    q_prod_q;
    logic signed [AMP_W+LUT_W:0]    i_scaled;
    logic signed [AMP_W+LUT_W:0]    q_scaled;
    logic                           lut_valid_q;
    logic                           prod_valid_q;

    // wraps modulo the table depth
    assign lut_addr = nco_phase_i + env_i.phase;

    sync_ram #(
        .entry_t (logic signed [LUT_W-1:0]),
        .DEPTH   (2**PHASE_W)
    ) u_sin_lut (
        .clk       (clk),
        .wr_en_i   (sin_wr_en_i),
        .wr_addr_i (lut_wr_addr_i),
        .wr_data_i (lut_wr_data_i),
        .rd_addr_i (lut_addr),
        .rd_data_o (sin_data)
    );

    sync_ram #(
        .entry_t (logic signed [LUT_W-1:0]),
        .DEPTH   (2**PHASE_W)
    ) u_cos_lut (
        .clk       (clk),
        .wr_en_i   (cos_wr_en_i),
        .wr_addr_i (lut_wr_addr_i),
        .wr_data_i (lut_wr_data_i),
        .rd_addr_i (lut_addr),
        .rd_data_o (cos_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // amplitude scaling, i from cosine and q from sine

    always_ff @(posedge clk) begin
        amp_q    <= env_i.amp;
        i_prod_q <= $signed({1'b0, amp_q}) * cos_data;
        q_prod_q <= $signed({1'b0, amp_q}) * sin_data;
        i_o      <= i_scaled[IQ_W-1:0];
        q_o      <= q_scaled[IQ_W-1:0];
    end

    assign i_scaled = i_prod_q >>> IQ_SHIFT;
    assign q_scaled = q_prod_q >>> IQ_SHIFT;

    always_ff @(posedge clk) begin
        if (rst) begin
            lut_valid_q  <= 1'b0;
            prod_valid_q <= 1'b0;
            valid_o      <= 1'b0;
        end else begin
            lut_valid_q  <= valid_i;
            prod_valid_q <= lut_valid_q;
            valid_o      <= prod_valid_q;
        end
    end

endmodule

`default_nettype wire

// ==== nco/nco_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module nco_bank
    import drive_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         ftw_wr_en_i,
    input  wire [QUBIT_W-1:0]           ftw_qubit_i,
    input  wire [FTW_W-1:0]             ftw_data_i,
    input  wire                         rz_strobe_i,
    input  wire phase_t                 phase_imm_i,
    input  wire [QUBIT_W-1:0]           qubit_sel_i,
    output logic                        rz_done_o,
    output phase_t                      nco_phase_o
);

    phase_t qubit_phase [NUM_QUBIT];
    logic   rz_applied_q;

    for (genvar q = 0; q < NUM_QUBIT; q++) begin : g_nco
        logic [FTW_W-1:0]   ftw_q;
        logic [FTW_W-1:0]   acc_q;
        phase_t             offset_q;
        logic               ftw_hit;
        logic               rz_hit;

        assign ftw_hit = ftw_wr_en_i && (ftw_qubit_i == QUBIT_W'(q));
        assign rz_hit  = rz_strobe_i && (qubit_sel_i == QUBIT_W'(q));

        always_ff @(posedge clk) begin
            if (rst) begin
                ftw_q    <= '0;
                acc_q    <= '0;
                offset_q <= '0;
            end else begin
                // new tuning word restarts the accumulator
                if (ftw_hit) begin
                    ftw_q <= ftw_data_i;
                    acc_q <= '0;
                end else begin
                    acc_q <= acc_q + ftw_q;
                end
                if (rz_hit) begin
                    offset_q <= offset_q + phase_imm_i;
                end
            end
        end

        // top bits of the accumulator plus rz offset
        assign qubit_phase[q] = acc_q[FTW_W-1 -: PHASE_W] + offset_q;
    end

    // done lines up with the first phase that carries the new offset
    always_ff @(posedge clk) begin
        if (rst) begin
            rz_applied_q <= 1'b0;
            rz_done_o    <= 1'b0;
            nco_phase_o  <= '0;
        end else begin
            rz_applied_q <= rz_strobe_i;
            rz_done_o    <= rz_applied_q;
            nco_phase_o  <= qubit_phase[qubit_sel_i];
        end
    end

endmodule

`default_nettype wire

// ==== envelope/envelope_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module envelope_reader
    import drive_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         env_wr_en_i,
    input  wire [ENV_ADDR_W-1:0]        env_wr_addr_i,
    input  wire env_word_t              env_wr_data_i,
    input  wire                         start_i,
    input  wire [ENV_ADDR_W-1:0]        start_addr_i,
    input  wire [ENV_ADDR_W-1:0]        stop_addr_i,
    output logic                        reading_o,
    output logic                        read_done_o,
    output logic                        env_valid_o,
    output env_word_t                   env_o
);

    logic [ENV_ADDR_W-1:0]  addr_q;
    logic [ENV_ADDR_W-1:0]  addr_next;
    logic [ENV_ADDR_W-1:0]  stop_q;
    logic                   range_ok;

    assign addr_next = addr_q + 1'b1;
    assign range_ok  = stop_addr_i > start_addr_i;

    sync_ram #(
        .entry_t (env_word_t),
        .DEPTH   (2**ENV_ADDR_W)
    ) u_env_mem (
        .clk       (clk),
        .wr_en_i   (env_wr_en_i),
        .wr_addr_i (env_wr_addr_i),
        .wr_data_i (env_wr_data_i),
        .rd_addr_i (addr_q),
        .rd_data_o (env_o)
    );

    // one address issued per cycle while reading
    always_ff @(posedge clk) begin
        if (rst) begin
            reading_o   <= 1'b0;
            read_done_o <= 1'b0;
            env_valid_o <= 1'b0;
            addr_q      <= '0;
        end else begin
            read_done_o <= 1'b0;
            env_valid_o <= reading_o;
            if (start_i) begin
                addr_q      <= start_addr_i;
                reading_o   <= range_ok;
                // empty range finishes straight away
                read_done_o <= ~range_ok;
            end else if (reading_o) begin
                addr_q <= addr_next;
                if (addr_next == stop_q) begin
                    reading_o   <= 1'b0;
                    read_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            stop_q <= stop_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import drive_cfg_pkg::*;
    import drive_types_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         inst_wr_en_i,
    input  wire [PC_W-1:0]              inst_wr_addr_i,
    input  wire inst_word_t             inst_wr_data_i,
    input  wire                         table_wr_en_i,
    input  wire [QUBIT_W-1:0]           table_wr_qubit_i,
    input  wire [INST_SEL_W-1:0]        table_wr_addr_i,
    input  wire table_entry_t           table_wr_data_i,
    input  wire                         pc_valid_i,
    input  wire [PC_W-1:0]              pc_i,
    output logic                        inst_valid_o,
    output logic [QUBIT_W-1:0]          qubit_sel_o,
    output logic                        rz_strobe_o,
    output phase_t                      phase_imm_o,
    output logic                        entry_valid_o,
    output logic [ENV_ADDR_W-1:0]       start_addr_o,
    output logic [ENV_ADDR_W-1:0]       stop_addr_o
);

    inst_word_t             list_rd_word;
    logic                   pc_valid_q;
    logic                   rz_q;
    logic [INST_SEL_W-1:0]  inst_sel_q;
    logic                   table_rd_q;
    table_entry_t           table_rd_data [NUM_QUBIT];
    table_entry_t           sel_entry;

    ////////////////////////////////////////////////////////////////////////////
    // instruction list

    sync_ram #(
        .entry_t (inst_word_t),
        .DEPTH   (2**PC_W)
    ) u_inst_list (
        .clk       (clk),
        .wr_en_i   (inst_wr_en_i),
        .wr_addr_i (inst_wr_addr_i),
        .wr_data_i (inst_wr_data_i),
        .rd_addr_i (pc_i),
        .rd_data_o (list_rd_word)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_valid_q   <= 1'b0;
            inst_valid_o <= 1'b0;
            qubit_sel_o  <= '0;
            rz_q         <= 1'b0;
        end else begin
            pc_valid_q   <= pc_valid_i;
            inst_valid_o <= pc_valid_q;
            if (pc_valid_q) begin
                qubit_sel_o <= list_rd_word.qubit;
                rz_q        <= list_rd_word.rz;
            end
        end
    end

    // immediate doubles as table index for pulse words
    always_ff @(posedge clk) begin
        if (pc_valid_q) begin
            phase_imm_o <= list_rd_word.imm;
            inst_sel_q  <= list_rd_word.imm[INST_SEL_W-1:0];
        end
    end

    assign rz_strobe_o = inst_valid_o & rz_q;

    ////////////////////////////////////////////////////////////////////////////
    // per-qubit tables

    for (genvar q = 0; q < NUM_QUBIT; q++) begin : g_table
        logic wr_en;

        assign wr_en = table_wr_en_i && (table_wr_qubit_i == QUBIT_W'(q));

        sync_ram #(
            .entry_t (table_entry_t),
            .DEPTH   (INST_TABLE_DEPTH)
        ) u_table (
            .clk       (clk),
            .wr_en_i   (wr_en),
            .wr_addr_i (table_wr_addr_i),
            .wr_data_i (table_wr_data_i),
            .rd_addr_i (inst_sel_q),
            .rd_data_o (table_rd_data[q])
        );
    end

    assign sel_entry = table_rd_data[qubit_sel_o];

    // entry is only taken for non-rz words
    always_ff @(posedge clk) begin
        if (rst) begin
            table_rd_q    <= 1'b0;
            entry_valid_o <= 1'b0;
        end else begin
            table_rd_q    <= inst_valid_o & ~rz_q;
            entry_valid_o <= table_rd_q;
        end
    end

    always_ff @(posedge clk) begin
        if (table_rd_q) begin
            start_addr_o <= sel_entry.start_addr;
            stop_addr_o  <= sel_entry.stop_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/sync_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 256
) (
    input  wire                        clk,
    input  wire                        wr_en_i,
    input  wire [$clog2(DEPTH)-1:0]    wr_addr_i,
    input  wire entry_t                wr_data_i,
    input  wire [$clog2(DEPTH)-1:0]    rd_addr_i,
    output entry_t                     rd_data_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, one cycle
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== common/drive_types_pkg.sv ====
`default_nettype none

package drive_types_pkg;

    import drive_cfg_pkg::*;

    typedef logic [PHASE_W-1:0] phase_t;

    typedef logic signed [IQ_W-1:0] iq_t;

    // instruction list word, 11 bits
    typedef struct packed {
        logic [QUBIT_W-1:0] qubit;
        logic               rz;
        phase_t             imm;
    } inst_word_t;

    // table entry, stop address is exclusive
    typedef struct packed {
        logic [ENV_ADDR_W-1:0] start_addr;
        logic [ENV_ADDR_W-1:0] stop_addr;
    } table_entry_t;

    // envelope sample
    typedef struct packed {
        phase_t             phase;
        logic [AMP_W-1:0]   amp;
    } env_word_t;

endpackage

`default_nettype wire

// ==== common/drive_cfg_pkg.sv ====
`default_nettype none

package drive_cfg_pkg;

    // qubit bank
    localparam int NUM_QUBIT = 4;
    localparam int QUBIT_W = 2;

    // instruction list, 64 entries
    localparam int PC_W = 6;

    // per-qubit instruction tables
    localparam int INST_TABLE_DEPTH = 8;
    localparam int INST_SEL_W = 3;

    // envelope memory, 256 entries
    localparam int ENV_ADDR_W = 8;

    // phase also sizes the sine/cosine tables
    localparam int PHASE_W = 8;
    localparam int AMP_W = 8;
    localparam int LUT_W = 8;

    // nco accumulator
    localparam int FTW_W = 16;

    // output samples
    localparam int IQ_W = 9;
    localparam int IQ_SHIFT = 7;

endpackage

`default_nettype wire
